// File: common/mem_pkg.sv
package mem_pkg;

  // Requester side widths
  localparam int ADDR_BITS = 32;
  localparam int WORD_BITS = 32;

  // A RAM row holds two cache words side by side
  localparam int HALF_COUNT = 2;
  localparam int ROW_BITS = WORD_BITS * HALF_COUNT;

  // 256 rows, row index taken from address bits 10:3
  localparam int ROW_INDEX_BITS = 8;
  localparam int ROW_COUNT = 1 << ROW_INDEX_BITS;
  localparam int ROW_LSB = 3;

  // Address bit 2 picks the upper half when set
  localparam int HALF_BIT = 2;

  // Cycles an access must be held before ram_hit
  localparam int RAM_LATENCY = 2;
  localparam int LAT_CNT_BITS = $clog2(RAM_LATENCY + 1);

  typedef logic [ADDR_BITS-1:0]      addr_t;
  typedef logic [WORD_BITS-1:0]      word_t;
  typedef logic [ROW_BITS-1:0]       row_t;
  typedef logic [ROW_INDEX_BITS-1:0] row_index_t;
  typedef logic [HALF_COUNT-1:0]     half_en_t;
  typedef logic [LAT_CNT_BITS-1:0]   lat_cnt_t;

endpackage

// File: common/arb_pkg.sv
package arb_pkg;

  // One state per requester plus the idle state
  typedef enum logic [2:0] {
    IDLE     = 3'b000,
    SP_LOAD  = 3'b001,
    SP_STORE = 3'b010,
    DCACHE   = 3'b011,
    ICACHE   = 3'b100
  } arb_state_t;

  // Requester slots, in falling priority
  localparam int REQ_COUNT    = 4;
  localparam int REQ_SP_LOAD  = 0;
  localparam int REQ_SP_STORE = 1;
  localparam int REQ_DCACHE   = 2;
  localparam int REQ_ICACHE   = 3;

endpackage

// File: memory_arbiter/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter (
  input  logic                CLK,
  input  logic                nRST,

  // Scratchpad load
  input  logic                sp_load,
  input  mem_pkg::addr_t      sp_load_addr,
  output mem_pkg::row_t       sp_load_data,
  output logic                sp_load_done,

  // Scratchpad store
  input  logic                sp_store,
  input  mem_pkg::addr_t      sp_store_addr,
  input  mem_pkg::row_t       sp_store_data,
  output logic                sp_store_done,

  // Data cache
  input  logic                dreq,
  input  logic                dwen,
  input  mem_pkg::addr_t      daddr,
  input  mem_pkg::word_t      dstore,
  output mem_pkg::word_t      dload,
  output logic                ddone,

  // Instruction cache, read only
  input  logic                ireq,
  input  mem_pkg::addr_t      iaddr,
  output mem_pkg::word_t      iload,
  output logic                idone,

  // RAM side
  output logic                ram_ren,
  output mem_pkg::half_en_t   ram_wen,
  output mem_pkg::row_index_t ram_row,
  output mem_pkg::row_t       ram_wdat,
  input  mem_pkg::row_t       ram_rdat,
  input  logic                ram_hit
);

  arb_pkg::arb_state_t           state;
  arb_pkg::arb_state_t           next_state;
  logic [arb_pkg::REQ_COUNT-1:0] done_vec;

  function automatic mem_pkg::row_index_t row_of(input mem_pkg::addr_t addr);
    return addr[mem_pkg::ROW_LSB +: mem_pkg::ROW_INDEX_BITS];
  endfunction

  // One-hot enable for the half the address points at
  function automatic mem_pkg::half_en_t half_of(input mem_pkg::addr_t addr);
    return mem_pkg::half_en_t'(1) << addr[mem_pkg::HALF_BIT];
  endfunction

  function automatic mem_pkg::word_t word_of(input mem_pkg::row_t row,
                                             input mem_pkg::addr_t addr);
    return row[addr[mem_pkg::HALF_BIT] * mem_pkg::WORD_BITS +: mem_pkg::WORD_BITS];
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= arb_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Fixed priority in IDLE, grant held until the RAM answers
  always_comb begin
    next_state = state;
    case (state)
      arb_pkg::IDLE: begin
        if (sp_load) next_state = arb_pkg::SP_LOAD;
        else if (sp_store) next_state = arb_pkg::SP_STORE;
        else if (dreq) next_state = arb_pkg::DCACHE;
        else if (ireq) next_state = arb_pkg::ICACHE;
      end
      default: begin
        if (ram_hit) next_state = arb_pkg::IDLE;
      end
    endcase
  end

  // Route the granted access to the RAM
  always_comb begin
    ram_ren  = 1'b0;
    ram_wen  = '0;
    ram_row  = '0;
    ram_wdat = '0;
    done_vec = '0;
    case (state)
      arb_pkg::SP_LOAD: begin
        ram_ren = 1'b1;
        ram_row = row_of(sp_load_addr);
        done_vec[arb_pkg::REQ_SP_LOAD] = ram_hit;
      end
      arb_pkg::SP_STORE: begin
        ram_wen  = '1;
        ram_row  = row_of(sp_store_addr);
        ram_wdat = sp_store_data;
        done_vec[arb_pkg::REQ_SP_STORE] = ram_hit;
      end
      arb_pkg::DCACHE: begin
        ram_row = row_of(daddr);
        if (dwen) begin
          // Word goes to both halves, only one is enabled
          ram_wen  = half_of(daddr);
          ram_wdat = {dstore, dstore};
        end else begin
          ram_ren = 1'b1;
        end
        done_vec[arb_pkg::REQ_DCACHE] = ram_hit;
      end
      arb_pkg::ICACHE: begin
        ram_ren = 1'b1;
        ram_row = row_of(iaddr);
        done_vec[arb_pkg::REQ_ICACHE] = ram_hit;
      end
      default: begin
      end
    endcase
  end

  // Read data only counts in the done cycle
  assign sp_load_data = ram_rdat;
  assign dload        = word_of(ram_rdat, daddr);
  assign iload        = word_of(ram_rdat, iaddr);

  assign sp_load_done  = done_vec[arb_pkg::REQ_SP_LOAD];
  assign sp_store_done = done_vec[arb_pkg::REQ_SP_STORE];
  assign ddone         = done_vec[arb_pkg::REQ_DCACHE];
  assign idone         = done_vec[arb_pkg::REQ_ICACHE];

  a_one_done: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0(done_vec))
    else $error("more than one done in the same cycle");

  a_idle_no_done: assert property (@(posedge CLK) disable iff (!nRST)
    (state == arb_pkg::IDLE) |-> (done_vec == '0))
    else $error("done raised while the arbiter is idle");

  a_rw_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    (ram_wen != '0) |-> !ram_ren)
    else $error("RAM read and write driven together");

endmodule

// File: hdl/ram_bank.sv
`timescale 1ns/1ps

module ram_bank (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                ram_ren,
  input  mem_pkg::half_en_t   ram_wen,
  input  mem_pkg::row_index_t ram_row,
  input  mem_pkg::row_t       ram_wdat,
  output mem_pkg::row_t       ram_rdat,
  output logic                ram_hit
);

  mem_pkg::row_t     rows [mem_pkg::ROW_COUNT];
  mem_pkg::lat_cnt_t cnt;
  logic              access;

  assign access = ram_ren | (|ram_wen);

  // Hit once the same access has been held long enough
  assign ram_hit = access && (cnt == mem_pkg::lat_cnt_t'(mem_pkg::RAM_LATENCY));

  assign ram_rdat = rows[ram_row];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end else if (!access || ram_hit) begin
      cnt <= '0;
    end else begin
      cnt <= mem_pkg::lat_cnt_t'(cnt + 1'b1);
    end
  end

  // Enabled halves commit at the end of the hit cycle
  always_ff @(posedge CLK) begin
    if (ram_hit) begin
      for (int h = 0; h < mem_pkg::HALF_COUNT; h++) begin
        if (ram_wen[h]) begin
          rows[ram_row][h*mem_pkg::WORD_BITS +: mem_pkg::WORD_BITS] <=
            ram_wdat[h*mem_pkg::WORD_BITS +: mem_pkg::WORD_BITS];
        end
      end
    end
  end

  // The requester side must not move a pending access
  a_hold_access: assert property (@(posedge CLK) disable iff (!nRST)
    (access && !ram_hit) |=>
      (access && $stable(ram_row) && $stable(ram_wen) && $stable(ram_ren)))
    else $error("RAM access changed before ram_hit");

endmodule

// File: hdl/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
  input  logic           CLK,
  input  logic           nRST,

  input  logic           sp_load,
  input  mem_pkg::addr_t sp_load_addr,
  output mem_pkg::row_t  sp_load_data,
  output logic           sp_load_done,

  input  logic           sp_store,
  input  mem_pkg::addr_t sp_store_addr,
  input  mem_pkg::row_t  sp_store_data,
  output logic           sp_store_done,

  input  logic           dreq,
  input  logic           dwen,
  input  mem_pkg::addr_t daddr,
  input  mem_pkg::word_t dstore,
  output mem_pkg::word_t dload,
  output logic           ddone,

  input  logic           ireq,
  input  mem_pkg::addr_t iaddr,
  output mem_pkg::word_t iload,
  output logic           idone
);

  // Arbiter to RAM
  logic                ram_ren;
  mem_pkg::half_en_t   ram_wen;
  mem_pkg::row_index_t ram_row;
  mem_pkg::row_t       ram_wdat;
  mem_pkg::row_t       ram_rdat;
  logic                ram_hit;

  memory_arbiter arb0 (
    .CLK           (CLK),
    .nRST          (nRST),
    .sp_load       (sp_load),
    .sp_load_addr  (sp_load_addr),
    .sp_load_data  (sp_load_data),
    .sp_load_done  (sp_load_done),
    .sp_store      (sp_store),
    .sp_store_addr (sp_store_addr),
    .sp_store_data (sp_store_data),
    .sp_store_done (sp_store_done),
    .dreq          (dreq),
    .dwen          (dwen),
    .daddr         (daddr),
    .dstore        (dstore),
    .dload         (dload),
    .ddone         (ddone),
    .ireq          (ireq),
    .iaddr         (iaddr),
    .iload         (iload),
    .idone         (idone),
    .ram_ren       (ram_ren),
    .ram_wen       (ram_wen),
    .ram_row       (ram_row),
    .ram_wdat      (ram_wdat),
    .ram_rdat      (ram_rdat),
    .ram_hit       (ram_hit)
  );

  ram_bank ram0 (
    .CLK      (CLK),
    .nRST     (nRST),
    .ram_ren  (ram_ren),
    .ram_wen  (ram_wen),
    .ram_row  (ram_row),
    .ram_wdat (ram_wdat),
    .ram_rdat (ram_rdat),
    .ram_hit  (ram_hit)
  );

endmodule

// File: bench/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int N_OPS       = 14;
  localparam int N_GRP_ENTRY = 7;
  localparam int N_GROUPS    = 2;
  localparam int DONE_LIMIT  = 20;
  localparam int WATCHDOG_NS =
    (N_OPS + N_GRP_ENTRY) * (mem_pkg::RAM_LATENCY + 4) * CLK_PERIOD + 40 * CLK_PERIOD;

  logic CLK;
  logic nRST;
  logic sp_load, sp_load_done, sp_store, sp_store_done;
  logic dreq, dwen, ddone, ireq, idone;
  mem_pkg::addr_t sp_load_addr, sp_store_addr, daddr, iaddr;
  mem_pkg::row_t  sp_load_data, sp_store_data;
  mem_pkg::word_t dstore, dload, iload;

  // Reference copy of the RAM, one 64-bit row per entry
  mem_pkg::row_t model [mem_pkg::ROW_COUNT];

  // Single access table
  int             op_slot [N_OPS];
  logic           op_wr   [N_OPS];
  mem_pkg::addr_t op_addr [N_OPS];
  mem_pkg::row_t  op_data [N_OPS];

  // Contention groups, all entries of a group raised together
  int             grp_slot [N_GRP_ENTRY];
  logic           grp_wr   [N_GRP_ENTRY];
  mem_pkg::addr_t grp_addr [N_GRP_ENTRY];
  mem_pkg::row_t  grp_data [N_GRP_ENTRY];
  int             grp_start [N_GROUPS] = '{0, 4};
  int             grp_len   [N_GROUPS] = '{4, 3};

  logic [63:0] rng;
  int          value_errors = 0;
  int          other_errors = 0;

  mem_subsystem dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  function automatic string slot_name(input int slot);
    case (slot)
      arb_pkg::REQ_SP_LOAD:  return "scratchpad load";
      arb_pkg::REQ_SP_STORE: return "scratchpad store";
      arb_pkg::REQ_DCACHE:   return "data cache";
      default:               return "instruction cache";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL t=%0t %s: actual %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic set_op(input int i, input int slot, input logic wr, input mem_pkg::addr_t addr);
    rng = xorshift64(rng);
    op_slot[i] = slot;
    op_wr[i]   = wr;
    op_addr[i] = addr;
    op_data[i] = wr ? rng : '0;
  endtask

  task automatic set_grp(input int i, input int slot, input logic wr, input mem_pkg::addr_t addr);
    rng = xorshift64(rng);
    grp_slot[i] = slot;
    grp_wr[i]   = wr;
    grp_addr[i] = addr;
    grp_data[i] = wr ? rng : '0;
  endtask

  task automatic build_tables();
    // Whole row store and load back
    set_op(0, arb_pkg::REQ_SP_STORE, 1'b1, 32'h0000_0028);
    set_op(1, arb_pkg::REQ_SP_LOAD, 1'b0, 32'h0000_0028);
    // Both halves of row 8 through the data cache
    set_op(2, arb_pkg::REQ_DCACHE, 1'b1, 32'h0000_0040);
    set_op(3, arb_pkg::REQ_DCACHE, 1'b1, 32'h0000_0044);
    set_op(4, arb_pkg::REQ_DCACHE, 1'b0, 32'h0000_0040);
    set_op(5, arb_pkg::REQ_DCACHE, 1'b0, 32'h0000_0044);
    set_op(6, arb_pkg::REQ_SP_LOAD, 1'b0, 32'h0000_0040);
    set_op(7, arb_pkg::REQ_DCACHE, 1'b1, 32'h0000_0044);
    set_op(8, arb_pkg::REQ_SP_LOAD, 1'b0, 32'h0000_0040);
    // Instruction fetch from rows the scratchpad wrote
    set_op(9, arb_pkg::REQ_SP_STORE, 1'b1, 32'h0000_0100);
    set_op(10, arb_pkg::REQ_ICACHE, 1'b0, 32'h0000_0100);
    set_op(11, arb_pkg::REQ_ICACHE, 1'b0, 32'h0000_0104);
    set_op(12, arb_pkg::REQ_ICACHE, 1'b0, 32'h0000_002C);
    set_op(13, arb_pkg::REQ_DCACHE, 1'b0, 32'h0000_0028);
    // All four at once
    set_grp(0, arb_pkg::REQ_SP_LOAD, 1'b0, 32'h0000_0100);
    set_grp(1, arb_pkg::REQ_SP_STORE, 1'b1, 32'h0000_0200);
    set_grp(2, arb_pkg::REQ_DCACHE, 1'b0, 32'h0000_0204);
    set_grp(3, arb_pkg::REQ_ICACHE, 1'b0, 32'h0000_002C);
    // Three at once, store first
    set_grp(4, arb_pkg::REQ_SP_STORE, 1'b1, 32'h0000_0300);
    set_grp(5, arb_pkg::REQ_DCACHE, 1'b1, 32'h0000_0308);
    set_grp(6, arb_pkg::REQ_ICACHE, 1'b0, 32'h0000_0304);
  endtask

  task automatic set_request(input int slot, input logic on, input logic wr,
                             input mem_pkg::addr_t addr, input mem_pkg::row_t data);
    case (slot)
      arb_pkg::REQ_SP_LOAD: begin
        sp_load      = on;
        sp_load_addr = addr;
      end
      arb_pkg::REQ_SP_STORE: begin
        sp_store      = on;
        sp_store_addr = addr;
        sp_store_data = data;
      end
      arb_pkg::REQ_DCACHE: begin
        dreq   = on;
        dwen   = wr;
        daddr  = addr;
        dstore = data[31:0];
      end
      default: begin
        ireq  = on;
        iaddr = addr;
      end
    endcase
  endtask

  function automatic logic [arb_pkg::REQ_COUNT-1:0] done_vector();
    logic [arb_pkg::REQ_COUNT-1:0] dv;
    dv = '0;
    dv[arb_pkg::REQ_SP_LOAD]  = sp_load_done;
    dv[arb_pkg::REQ_SP_STORE] = sp_store_done;
    dv[arb_pkg::REQ_DCACHE]   = ddone;
    dv[arb_pkg::REQ_ICACHE]   = idone;
    return dv;
  endfunction

  // Row index from bits 10:3, bit 2 picks the upper word
  function automatic mem_pkg::row_t predict_read(input int slot, input mem_pkg::addr_t addr);
    mem_pkg::row_t row;
    row = model[addr[10:3]];
    if (slot == arb_pkg::REQ_SP_LOAD) return row;
    return {32'h0, (addr[2] ? row[63:32] : row[31:0])};
  endfunction

  task automatic complete_access(input int slot, input logic wr, input mem_pkg::addr_t addr,
                                 input mem_pkg::row_t data);
    case (slot)
      arb_pkg::REQ_SP_LOAD:  check_value("sp_load_data", sp_load_data, predict_read(slot, addr));
      arb_pkg::REQ_SP_STORE: model[addr[10:3]] = data;
      arb_pkg::REQ_DCACHE: begin
        if (!wr) check_value("dload", {32'h0, dload}, predict_read(slot, addr));
        else if (addr[2]) model[addr[10:3]][63:32] = data[31:0];
        else model[addr[10:3]][31:0] = data[31:0];
      end
      default: check_value("iload", {32'h0, iload}, predict_read(slot, addr));
    endcase
  endtask

  task automatic check_idle(input int n);
    repeat (n) begin
      @(negedge CLK);
      check_value("done outputs", 64'(done_vector()), 64'h0);
    end
  endtask

  task automatic run_single(input int i);
    int cycles;
    logic seen;
    logic [arb_pkg::REQ_COUNT-1:0] others;
    cycles = 0;
    seen = 1'b0;
    @(posedge CLK);
    #DRIVE_DELAY;
    set_request(op_slot[i], 1'b1, op_wr[i], op_addr[i], op_data[i]);
    while (!seen && cycles < DONE_LIMIT) begin
      @(posedge CLK);
      cycles++;
      @(negedge CLK);
      others = done_vector();
      seen = others[op_slot[i]];
      others[op_slot[i]] = 1'b0;
      check_value("other done outputs", 64'(others), 64'h0);
    end
    if (seen) begin
      complete_access(op_slot[i], op_wr[i], op_addr[i], op_data[i]);
      check_value("latency", 64'(cycles), 64'(mem_pkg::RAM_LATENCY + 1));
    end else begin
      other_errors++;
      $display("ERROR t=%0t: op %0d got no done from the %s within %0d cycles",
               $time, i, slot_name(op_slot[i]), DONE_LIMIT);
    end
    @(posedge CLK);
    #DRIVE_DELAY;
    set_request(op_slot[i], 1'b0, 1'b0, '0, '0);
  endtask

  task automatic run_group(input int g);
    logic [arb_pkg::REQ_COUNT-1:0] pending;
    logic [arb_pkg::REQ_COUNT-1:0] retire;
    logic [arb_pkg::REQ_COUNT-1:0] dv;
    int entry [arb_pkg::REQ_COUNT];
    int order [$];
    int expect_order [$];
    int cycles;
    int j;
    pending = '0;
    retire = '0;
    cycles = 0;
    @(posedge CLK);
    #DRIVE_DELAY;
    for (int k = 0; k < grp_len[g]; k++) begin
      j = grp_start[g] + k;
      entry[grp_slot[j]] = j;
      pending[grp_slot[j]] = 1'b1;
      set_request(grp_slot[j], 1'b1, grp_wr[j], grp_addr[j], grp_data[j]);
    end
    // Priority follows the slot number
    for (int s = 0; s < arb_pkg::REQ_COUNT; s++) begin
      if (pending[s]) expect_order.push_back(s);
    end
    while (pending != '0 && cycles < DONE_LIMIT * arb_pkg::REQ_COUNT) begin
      @(posedge CLK);
      #DRIVE_DELAY;
      for (int s = 0; s < arb_pkg::REQ_COUNT; s++) begin
        if (retire[s]) set_request(s, 1'b0, 1'b0, '0, '0);
      end
      retire = '0;
      cycles++;
      @(negedge CLK);
      dv = done_vector();
      check_value("unexpected done outputs", 64'(dv & ~pending), 64'h0);
      for (int s = 0; s < arb_pkg::REQ_COUNT; s++) begin
        if (dv[s] && pending[s]) begin
          j = entry[s];
          order.push_back(s);
          complete_access(s, grp_wr[j], grp_addr[j], grp_data[j]);
          pending[s] = 1'b0;
          retire[s] = 1'b1;
        end
      end
    end
    if (pending != '0) begin
      other_errors++;
      $display("ERROR t=%0t: group %0d left requests without a done, mask %b",
               $time, g, pending);
    end
    @(posedge CLK);
    #DRIVE_DELAY;
    for (int s = 0; s < arb_pkg::REQ_COUNT; s++) begin
      if (retire[s] || pending[s]) set_request(s, 1'b0, 1'b0, '0, '0);
    end
    for (int k = 0; k < order.size() && k < expect_order.size(); k++) begin
      check_value($sformatf("group %0d done order %0d", g, k),
                  64'(order[k]), 64'(expect_order[k]));
    end
  endtask

  initial begin
    nRST = 1'b0;
    sp_load = 1'b0;
    sp_load_addr = '0;
    sp_store = 1'b0;
    sp_store_addr = '0;
    sp_store_data = '0;
    dreq = 1'b0;
    dwen = 1'b0;
    daddr = '0;
    dstore = '0;
    ireq = 1'b0;
    iaddr = '0;
    rng = 64'd34;
    for (int r = 0; r < mem_pkg::ROW_COUNT; r++) model[r] = '0;
    build_tables();
    repeat (2) @(posedge CLK);
    #DRIVE_DELAY;
    nRST = 1'b1;
    check_idle(6);
    for (int i = 0; i < N_OPS; i++) run_single(i);
    for (int g = 0; g < N_GROUPS; g++) run_group(g);
    check_idle(4);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Stall guard
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: run stalled, still busy after %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: mem_subsystem.f
common/mem_pkg.sv
common/arb_pkg.sv
memory_arbiter/memory_arbiter.sv
hdl/ram_bank.sv
hdl/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f mem_subsystem.f --top-module mem_subsystem_tb -o mem_subsystem_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/mem_subsystem_sim > sim.log 2>&1
cat sim.log

grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
